// File: verif/mem_unit_trace.txt
# port rw addr byteen wdata tag expected count (port I = instruction, D = data)
# count > 1 repeats the line with addr+4k, wdata+k, tag+k, expected+k
D 1 ff000000 f a5000000 00 00000000 64
D 1 ff000010 3 0000beef 00 00000000 1
D 1 ff000024 c 12340000 00 00000000 1
D 0 ff000000 f 00000000 40 a5000000 4
D 0 ff000010 f 00000000 44 a500beef 1
D 0 ff000014 f 00000000 45 a5000005 4
D 0 ff000024 f 00000000 49 12340009 1
D 0 ff000028 f 00000000 4a a500000a 54
D 1 00001000 f 11223344 01 00000000 1
D 1 00001004 f 55667788 02 00000000 1
D 1 00001004 6 00aabb00 03 00000000 1
D 1 00002000 1 000000ee 04 00000000 1
I 0 00001000 f 00000000 10 11223344 1
D 0 00001004 f 00000000 80 55aabb88 1
I 0 00003000 f 00000000 11 fffff3ff 1
D 0 00002000 f 00000000 81 fffff7ee 1
D 0 ff0000fc f 00000000 82 a500003f 1
I 0 00001004 f 00000000 12 55aabb88 1
D 0 00005000 f 00000000 83 ffffebff 1
I 0 00000040 f 00000000 13 ffffffef 1
D 0 0000100c f 00000000 84 fffffbfc 1

// File: files.f
logic/mem_unit_pkg.sv
logic/smem_switch.sv
logic/shared_mem.sv
logic/mem_arb.sv
logic/mem_unit.sv
verif/mem_model.sv
verif/mem_unit_tb.sv

// File: Bender.yml
package:
  name: mem_unit

sources:
  - logic/mem_unit_pkg.sv
  - logic/smem_switch.sv
  - logic/shared_mem.sv
  - logic/mem_arb.sv
  - logic/mem_unit.sv
  - target: test
    files:
      - verif/mem_model.sv
      - verif/mem_unit_tb.sv

// File: verif/mem_unit_tb.sv
`timescale 1ns/10ps

module mem_unit_tb;

    import mem_unit_pkg::*;

    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 500;

    typedef struct packed {
        logic      instr;
        logic      rw;
        addr_t     addr;
        byteen_t   byteen;
        data_t     wdata;
        core_tag_t tag;
        data_t     exp;
    } trace_entry_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_req_valid;
    addr_t     instr_req_addr;
    core_tag_t instr_req_tag;
    logic      instr_req_ready;
    logic      instr_rsp_valid;
    data_t     instr_rsp_data;
    core_tag_t instr_rsp_tag;
    logic      instr_rsp_ready;
    logic      data_req_valid;
    logic      data_req_rw;
    addr_t     data_req_addr;
    byteen_t   data_req_byteen;
    data_t     data_req_data;
    core_tag_t data_req_tag;
    logic      data_req_ready;
    logic      data_rsp_valid;
    data_t     data_rsp_data;
    core_tag_t data_rsp_tag;
    logic      data_rsp_ready;
    logic      mem_req_valid;
    logic      mem_req_rw;
    addr_t     mem_req_addr;
    byteen_t   mem_req_byteen;
    data_t     mem_req_data;
    mem_tag_t  mem_req_tag;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    data_t     mem_rsp_data;
    mem_tag_t  mem_rsp_tag;
    logic      mem_rsp_ready;

    integer       seed = 32'h32e0;
    int           value_errors = 0;
    int           protocol_errors = 0;
    logic         timed_out = 1'b0;
    logic         smem_due = 1'b0;
    core_tag_t    smem_due_tag;
    trace_entry_t trace [$];
    trace_entry_t exp_instr [$];
    trace_entry_t exp_writes [$];
    data_t        exp_data_rsp [core_tag_t];

    mem_unit UUT (.*);

    mem_model mem_model (.*);

    always #5 clk = ~clk;

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_tag(string name, core_tag_t got, core_tag_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_mem_tag(string name, mem_tag_t got, mem_tag_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_byteen(string name, byteen_t got, byteen_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    function automatic logic in_window(addr_t addr);
        return addr[ADDR_WIDTH-1:SMEM_WIN_LSB] == SMEM_BASE;
    endfunction

    // A count above one repeats the line on consecutive words
    task automatic read_trace();
        int           fd;
        int           n;
        int           count;
        string        line;
        byte          port;
        logic         rw;
        addr_t        addr;
        byteen_t      be;
        data_t        wdata;
        core_tag_t    tag;
        data_t        exp;
        trace_entry_t e;
        fd = $fopen("verif/mem_unit_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/mem_unit_trace.txt");
            protocol_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 8 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h %h %d",
                        port, rw, addr, be, wdata, tag, exp, count);
            if (n != 8) begin
                $display("Malformed trace line: %s", line);
                protocol_errors++;
                continue;
            end
            for (int k = 0; k < count; k++) begin
                e.instr  = (port == "I");
                e.rw     = rw;
                e.addr   = addr + 4 * k;
                e.byteen = be;
                e.wdata  = wdata + k;
                e.tag    = core_tag_t'(tag + k);
                e.exp    = exp + k;
                trace.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic send_request(trace_entry_t e);
        int   cycles;
        logic ready;
        cycles = 0;
        if (e.instr) begin
            instr_req_valid = 1'b1;
            instr_req_addr  = e.addr;
            instr_req_tag   = e.tag;
        end else begin
            data_req_valid  = 1'b1;
            data_req_rw     = e.rw;
            data_req_addr   = e.addr;
            data_req_byteen = e.byteen;
            data_req_data   = e.wdata;
            data_req_tag    = e.tag;
        end
        if (!e.rw && e.instr) begin
            exp_instr.push_back(e);
        end else if (!e.rw) begin
            exp_data_rsp[e.tag] = e.exp;
        end else if (!in_window(e.addr)) begin
            exp_writes.push_back(e);
        end
        @(negedge clk);
        ready = e.instr ? instr_req_ready : data_req_ready;
        while (!ready && !timed_out) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: request to address %h was never accepted", e.addr);
                protocol_errors++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                ready = e.instr ? instr_req_ready : data_req_ready;
            end
        end
        @(posedge clk);
        #1;
        if (e.instr) begin
            instr_req_valid = 1'b0;
        end else begin
            data_req_valid = 1'b0;
        end
        if (ready && !e.instr && !e.rw && in_window(e.addr)) begin
            smem_due     = 1'b1;
            smem_due_tag = e.tag;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            #1;
            instr_rsp_ready = ($random(seed) & 3) != 0;
            data_rsp_ready  = ($random(seed) & 3) != 0;
        end
    end

    // Outputs settle by mid-cycle, so transfers are judged at the falling edge
    always @(negedge clk) begin : monitor
        trace_entry_t e;
        if (smem_due) begin
            if (!data_rsp_valid) begin
                $display("Shared-memory read %h gave no response one cycle later", smem_due_tag);
                protocol_errors++;
            end else begin
                check_tag("data_rsp_tag", data_rsp_tag, smem_due_tag);
            end
            smem_due = 1'b0;
        end
        if (data_rsp_valid && data_rsp_ready) begin
            if (exp_data_rsp.exists(data_rsp_tag)) begin
                check_data("data_rsp_data", data_rsp_data, exp_data_rsp[data_rsp_tag]);
                exp_data_rsp.delete(data_rsp_tag);
            end else begin
                $display("Unexpected data response with tag %h", data_rsp_tag);
                protocol_errors++;
            end
        end
        if (instr_rsp_valid && instr_rsp_ready) begin
            if (exp_instr.size() == 0) begin
                $display("Unexpected instruction response with tag %h", instr_rsp_tag);
                protocol_errors++;
            end else begin
                e = exp_instr.pop_front();
                check_tag("instr_rsp_tag", instr_rsp_tag, e.tag);
                check_data("instr_rsp_data", instr_rsp_data, e.exp);
            end
        end
        if (mem_req_valid && mem_req_ready && mem_req_rw) begin
            if (exp_writes.size() == 0) begin
                $display("Unexpected write on the memory bus to %h", mem_req_addr);
                protocol_errors++;
            end else begin
                e = exp_writes.pop_front();
                check_addr("mem_req_addr", mem_req_addr, e.addr);
                check_data("mem_req_data", mem_req_data, e.wdata);
                check_byteen("mem_req_byteen", mem_req_byteen, e.byteen);
                check_mem_tag("mem_req_tag", mem_req_tag, {SRC_DATA, e.tag});
            end
        end
    end

    initial begin : main
        int cycles;
        rst_n           = 1'b0;
        instr_req_valid = 1'b0;
        instr_req_addr  = '0;
        instr_req_tag   = '0;
        instr_rsp_ready = 1'b1;
        data_req_valid  = 1'b0;
        data_req_rw     = 1'b0;
        data_req_addr   = '0;
        data_req_byteen = '0;
        data_req_data   = '0;
        data_req_tag    = '0;
        data_rsp_ready  = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (instr_rsp_valid !== 1'b0 || data_rsp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
            $display("Response or memory request valid is not low after reset");
            protocol_errors++;
        end
        read_trace();
        @(posedge clk);
        #1;
        for (int i = 0; i < trace.size() && !timed_out; i++) begin
            // Neighbouring fetch and data read go out together and compete for the bus
            if (i + 1 < trace.size() && trace[i].instr != trace[i + 1].instr
                && !trace[i].rw && !trace[i + 1].rw) begin
                fork
                    send_request(trace[i]);
                    send_request(trace[i + 1]);
                join
                i++;
            end else begin
                send_request(trace[i]);
            end
        end
        cycles = 0;
        while ((exp_data_rsp.num() > 0 || exp_instr.size() > 0 || exp_writes.size() > 0)
               && !timed_out) begin
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("Timeout: %0d data reads, %0d fetches, %0d writes still outstanding",
                         exp_data_rsp.num(), exp_instr.size(), exp_writes.size());
                protocol_errors++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        // Quiet window to catch duplicate responses
        repeat (10) @(negedge clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/mem_model.sv
`timescale 1ns/10ps

module mem_model (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   mem_req_valid,
    input  logic                   mem_req_rw,
    input  mem_unit_pkg::addr_t    mem_req_addr,
    input  mem_unit_pkg::byteen_t  mem_req_byteen,
    input  mem_unit_pkg::data_t    mem_req_data,
    input  mem_unit_pkg::mem_tag_t mem_req_tag,
    output logic                   mem_req_ready,

    output logic                   mem_rsp_valid,
    output mem_unit_pkg::data_t    mem_rsp_data,
    output mem_unit_pkg::mem_tag_t mem_rsp_tag,
    input  logic                   mem_rsp_ready
);

    import mem_unit_pkg::*;

    integer   seed = 32'h32e0;
    int       cycle = 0;
    int       last_due = 0;
    data_t    store [addr_t];
    data_t    rsp_data_q [$];
    mem_tag_t rsp_tag_q [$];
    int       rsp_due_q [$];

    // Unwritten words read as the inverted word address
    function automatic data_t load_word(addr_t word_addr);
        return store.exists(word_addr) ? store[word_addr] : ~word_addr;
    endfunction

    // Idle bus before the first clock edge
    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
    end

    always @(posedge clk) begin : model
        addr_t word_addr;
        data_t word;
        int    due;
        cycle++;
        if (!rst_n) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                word_addr = mem_req_addr >> 2;
                word = load_word(word_addr);
                if (mem_req_rw) begin
                    for (int i = 0; i < WORD_BYTES; i++) begin
                        if (mem_req_byteen[i]) begin
                            word[i*8 +: 8] = mem_req_data[i*8 +: 8];
                        end
                    end
                    store[word_addr] = word;
                end else begin
                    // Random latency that never overtakes an older read
                    due = cycle + 1 + ({$random(seed)} % 8);
                    last_due = (due > last_due) ? due : last_due;
                    rsp_data_q.push_back(word);
                    rsp_tag_q.push_back(mem_req_tag);
                    rsp_due_q.push_back(last_due);
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_data_q.pop_front());
                void'(rsp_tag_q.pop_front());
                void'(rsp_due_q.pop_front());
            end
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= rsp_data_q[0];
                mem_rsp_tag   <= rsp_tag_q[0];
            end else begin
                mem_rsp_valid <= 1'b0;
            end
            mem_req_ready <= ($random(seed) & 3) != 0;
        end
    end

endmodule

// File: logic/mem_unit.sv
`timescale 1ns/10ps

module mem_unit (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    instr_req_valid,
    input  mem_unit_pkg::addr_t     instr_req_addr,
    input  mem_unit_pkg::core_tag_t instr_req_tag,
    output logic                    instr_req_ready,
    output logic                    instr_rsp_valid,
    output mem_unit_pkg::data_t     instr_rsp_data,
    output mem_unit_pkg::core_tag_t instr_rsp_tag,
    input  logic                    instr_rsp_ready,

    input  logic                    data_req_valid,
    input  logic                    data_req_rw,
    input  mem_unit_pkg::addr_t     data_req_addr,
    input  mem_unit_pkg::byteen_t   data_req_byteen,
    input  mem_unit_pkg::data_t     data_req_data,
    input  mem_unit_pkg::core_tag_t data_req_tag,
    output logic                    data_req_ready,
    output logic                    data_rsp_valid,
    output mem_unit_pkg::data_t     data_rsp_data,
    output mem_unit_pkg::core_tag_t data_rsp_tag,
    input  logic                    data_rsp_ready,

    output logic                    mem_req_valid,
    output logic                    mem_req_rw,
    output mem_unit_pkg::addr_t     mem_req_addr,
    output mem_unit_pkg::byteen_t   mem_req_byteen,
    output mem_unit_pkg::data_t     mem_req_data,
    output mem_unit_pkg::mem_tag_t  mem_req_tag,
    input  logic                    mem_req_ready,
    input  logic                    mem_rsp_valid,
    input  mem_unit_pkg::data_t     mem_rsp_data,
    input  mem_unit_pkg::mem_tag_t  mem_rsp_tag,
    output logic                    mem_rsp_ready
);

    import mem_unit_pkg::*;

    // Switch to scratchpad
    logic      smem_req_valid;
    logic      smem_req_rw;
    addr_t     smem_req_addr;
    byteen_t   smem_req_byteen;
    data_t     smem_req_data;
    core_tag_t smem_req_tag;
    logic      smem_req_ready;
    logic      smem_rsp_valid;
    data_t     smem_rsp_data;
    core_tag_t smem_rsp_tag;
    logic      smem_rsp_ready;

    // Switch to arbiter
    logic      glob_req_valid;
    logic      glob_req_rw;
    addr_t     glob_req_addr;
    byteen_t   glob_req_byteen;
    data_t     glob_req_data;
    core_tag_t glob_req_tag;
    logic      glob_req_ready;
    logic      glob_rsp_valid;
    data_t     glob_rsp_data;
    core_tag_t glob_rsp_tag;
    logic      glob_rsp_ready;

    smem_switch smem_switch (.*);

    shared_mem shared_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (smem_req_valid),
        .req_rw     (smem_req_rw),
        .req_addr   (smem_req_addr),
        .req_byteen (smem_req_byteen),
        .req_data   (smem_req_data),
        .req_tag    (smem_req_tag),
        .req_ready  (smem_req_ready),
        .rsp_valid  (smem_rsp_valid),
        .rsp_data   (smem_rsp_data),
        .rsp_tag    (smem_rsp_tag),
        .rsp_ready  (smem_rsp_ready)
    );

    mem_arb mem_arb (.*);

endmodule

// File: logic/mem_arb.sv
`timescale 1ns/10ps

module mem_arb (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    instr_req_valid,
    input  mem_unit_pkg::addr_t     instr_req_addr,
    input  mem_unit_pkg::core_tag_t instr_req_tag,
    output logic                    instr_req_ready,

    input  logic                    glob_req_valid,
    input  logic                    glob_req_rw,
    input  mem_unit_pkg::addr_t     glob_req_addr,
    input  mem_unit_pkg::byteen_t   glob_req_byteen,
    input  mem_unit_pkg::data_t     glob_req_data,
    input  mem_unit_pkg::core_tag_t glob_req_tag,
    output logic                    glob_req_ready,

    output logic                    mem_req_valid,
    output logic                    mem_req_rw,
    output mem_unit_pkg::addr_t     mem_req_addr,
    output mem_unit_pkg::byteen_t   mem_req_byteen,
    output mem_unit_pkg::data_t     mem_req_data,
    output mem_unit_pkg::mem_tag_t  mem_req_tag,
    input  logic                    mem_req_ready,

    input  logic                    mem_rsp_valid,
    input  mem_unit_pkg::data_t     mem_rsp_data,
    input  mem_unit_pkg::mem_tag_t  mem_rsp_tag,
    output logic                    mem_rsp_ready,

    output logic                    instr_rsp_valid,
    output mem_unit_pkg::data_t     instr_rsp_data,
    output mem_unit_pkg::core_tag_t instr_rsp_tag,
    input  logic                    instr_rsp_ready,

    output logic                    glob_rsp_valid,
    output mem_unit_pkg::data_t     glob_rsp_data,
    output mem_unit_pkg::core_tag_t glob_rsp_tag,
    input  logic                    glob_rsp_ready
);

    import mem_unit_pkg::*;

    logic [1:0] src_valid;
    logic       prio_src;
    logic       grant_src;
    logic       rsp_src;

    assign src_valid[SRC_INSTR] = instr_req_valid;
    assign src_valid[SRC_DATA]  = glob_req_valid;

    assign grant_src = src_valid[prio_src] ? prio_src : !prio_src;

    // Past the winner after a transfer, kept on a stalled offer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_src <= SRC_INSTR;
        end else if (mem_req_valid) begin
            if (mem_req_ready) begin
                prio_src <= !grant_src;
            end else begin
                prio_src <= grant_src;
            end
        end
    end

    assign mem_req_valid = |src_valid;

    always_comb begin
        if (grant_src == SRC_DATA) begin
            mem_req_rw     = glob_req_rw;
            mem_req_addr   = glob_req_addr;
            mem_req_byteen = glob_req_byteen;
            mem_req_data   = glob_req_data;
            mem_req_tag    = {SRC_DATA, glob_req_tag};
        end else begin
            // Instruction fetch is a full-word read
            mem_req_rw     = 1'b0;
            mem_req_addr   = instr_req_addr;
            mem_req_byteen = '1;
            mem_req_data   = '0;
            mem_req_tag    = {SRC_INSTR, instr_req_tag};
        end
    end

    assign instr_req_ready = mem_req_ready && (grant_src == SRC_INSTR);
    assign glob_req_ready  = mem_req_ready && (grant_src == SRC_DATA);

    // Return path steered by the source bit
    assign rsp_src = mem_rsp_tag[CORE_TAG_WIDTH];

    assign instr_rsp_valid = mem_rsp_valid && (rsp_src == SRC_INSTR);
    assign instr_rsp_data  = mem_rsp_data;
    assign instr_rsp_tag   = mem_rsp_tag[CORE_TAG_WIDTH-1:0];

    assign glob_rsp_valid = mem_rsp_valid && (rsp_src == SRC_DATA);
    assign glob_rsp_data  = mem_rsp_data;
    assign glob_rsp_tag   = mem_rsp_tag[CORE_TAG_WIDTH-1:0];

    assign mem_rsp_ready = (rsp_src == SRC_DATA) ? glob_rsp_ready : instr_rsp_ready;

endmodule

// File: logic/shared_mem.sv
`timescale 1ns/10ps

module shared_mem (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_valid,
    input  logic                    req_rw,
    input  mem_unit_pkg::addr_t     req_addr,
    input  mem_unit_pkg::byteen_t   req_byteen,
    input  mem_unit_pkg::data_t     req_data,
    input  mem_unit_pkg::core_tag_t req_tag,
    output logic                    req_ready,

    output logic                    rsp_valid,
    output mem_unit_pkg::data_t     rsp_data,
    output mem_unit_pkg::core_tag_t rsp_tag,
    input  logic                    rsp_ready
);

    import mem_unit_pkg::*;

    smem_addr_t                word_idx;
    logic [SMEM_BANK_BITS-1:0] bank_sel;
    logic [SMEM_ROW_BITS-1:0]  row_sel;
    logic                      req_fire;
    logic                      wr_fire;
    logic                      rd_fire;
    data_t                     bank_rdata [SMEM_NUM_BANKS];

    // Offset in window is [warp][thread][word sel][byte]
    // Index becomes [warp][word sel][thread], so neighbour threads hit other banks
    assign word_idx = {
        req_addr[WORD_OFF_BITS + WORD_SEL_BITS + NT_BITS +: NW_BITS],
        req_addr[WORD_OFF_BITS +: WORD_SEL_BITS],
        req_addr[WORD_OFF_BITS + WORD_SEL_BITS +: NT_BITS]
    };

    assign bank_sel = word_idx[SMEM_BANK_BITS-1:0];
    assign row_sel  = word_idx[SMEM_ADDR_WIDTH-1:SMEM_BANK_BITS];

    // Stall only while a response is stuck
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = req_fire && req_rw;
    assign rd_fire   = req_fire && !req_rw;

    for (genvar b = 0; b < SMEM_NUM_BANKS; b++) begin : g_bank
        data_t mem [SMEM_BANK_WORDS];

        always_ff @(posedge clk) begin
            if (wr_fire && (bank_sel == SMEM_BANK_BITS'(b))) begin
                for (int i = 0; i < WORD_BYTES; i++) begin
                    if (req_byteen[i]) begin
                        mem[row_sel][i*8 +: 8] <= req_data[i*8 +: 8];
                    end
                end
            end
        end

        assign bank_rdata[b] = mem[row_sel];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Loads only on a new read, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data <= bank_rdata[bank_sel];
            rsp_tag  <= req_tag;
        end
    end

endmodule

// File: logic/smem_switch.sv
`timescale 1ns/10ps

module smem_switch (
    input  logic                    data_req_valid,
    input  logic                    data_req_rw,
    input  mem_unit_pkg::addr_t     data_req_addr,
    input  mem_unit_pkg::byteen_t   data_req_byteen,
    input  mem_unit_pkg::data_t     data_req_data,
    input  mem_unit_pkg::core_tag_t data_req_tag,
    output logic                    data_req_ready,

    output logic                    smem_req_valid,
    output logic                    smem_req_rw,
    output mem_unit_pkg::addr_t     smem_req_addr,
    output mem_unit_pkg::byteen_t   smem_req_byteen,
    output mem_unit_pkg::data_t     smem_req_data,
    output mem_unit_pkg::core_tag_t smem_req_tag,
    input  logic                    smem_req_ready,

    output logic                    glob_req_valid,
    output logic                    glob_req_rw,
    output mem_unit_pkg::addr_t     glob_req_addr,
    output mem_unit_pkg::byteen_t   glob_req_byteen,
    output mem_unit_pkg::data_t     glob_req_data,
    output mem_unit_pkg::core_tag_t glob_req_tag,
    input  logic                    glob_req_ready,

    input  logic                    smem_rsp_valid,
    input  mem_unit_pkg::data_t     smem_rsp_data,
    input  mem_unit_pkg::core_tag_t smem_rsp_tag,
    output logic                    smem_rsp_ready,

    input  logic                    glob_rsp_valid,
    input  mem_unit_pkg::data_t     glob_rsp_data,
    input  mem_unit_pkg::core_tag_t glob_rsp_tag,
    output logic                    glob_rsp_ready,

    output logic                    data_rsp_valid,
    output mem_unit_pkg::data_t     data_rsp_data,
    output mem_unit_pkg::core_tag_t data_rsp_tag,
    input  logic                    data_rsp_ready
);

    import mem_unit_pkg::*;

    logic is_smem;

    assign is_smem = (data_req_addr[ADDR_WIDTH-1:SMEM_WIN_LSB] == SMEM_BASE);

    // Payload goes to both sides, only one valid
    assign smem_req_valid  = data_req_valid && is_smem;
    assign smem_req_rw     = data_req_rw;
    assign smem_req_addr   = data_req_addr;
    assign smem_req_byteen = data_req_byteen;
    assign smem_req_data   = data_req_data;
    assign smem_req_tag    = data_req_tag;

    assign glob_req_valid  = data_req_valid && !is_smem;
    assign glob_req_rw     = data_req_rw;
    assign glob_req_addr   = data_req_addr;
    assign glob_req_byteen = data_req_byteen;
    assign glob_req_data   = data_req_data;
    assign glob_req_tag    = data_req_tag;

    assign data_req_ready = is_smem ? smem_req_ready : glob_req_ready;

    // Shared memory wins, global waits
    assign data_rsp_valid = smem_rsp_valid || glob_rsp_valid;
    assign data_rsp_data  = smem_rsp_valid ? smem_rsp_data : glob_rsp_data;
    assign data_rsp_tag   = smem_rsp_valid ? smem_rsp_tag : glob_rsp_tag;

    assign smem_rsp_ready = data_rsp_ready;
    assign glob_rsp_ready = data_rsp_ready && !smem_rsp_valid;

endmodule

// File: logic/mem_unit_pkg.sv
package mem_unit_pkg;

    // Bus widths
    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int WORD_BYTES     = DATA_WIDTH / 8;
    localparam int WORD_OFF_BITS  = $clog2(WORD_BYTES);
    localparam int CORE_TAG_WIDTH = 8;
    localparam int MEM_TAG_WIDTH  = CORE_TAG_WIDTH + 1;

    // Thread layout of the scratchpad
    localparam int NUM_THREADS   = 4;
    localparam int NUM_WARPS     = 4;
    localparam int NT_BITS       = $clog2(NUM_THREADS);
    localparam int NW_BITS       = $clog2(NUM_WARPS);
    localparam int WORD_SEL_BITS = 2;

    localparam int SMEM_ADDR_WIDTH = NT_BITS + WORD_SEL_BITS + NW_BITS;
    localparam int SMEM_WORDS      = 64;
    localparam int SMEM_NUM_BANKS  = 4;
    localparam int SMEM_BANK_BITS  = $clog2(SMEM_NUM_BANKS);
    localparam int SMEM_BANK_WORDS = SMEM_WORDS / SMEM_NUM_BANKS;
    localparam int SMEM_ROW_BITS   = SMEM_ADDR_WIDTH - SMEM_BANK_BITS;

    // Shared window is 0xFF0000xx
    localparam int SMEM_WIN_LSB = 8;
    localparam logic [ADDR_WIDTH-SMEM_WIN_LSB-1:0] SMEM_BASE = 24'hFF0000;

    // Source bit on top of the memory tag
    localparam logic SRC_INSTR = 1'b0;
    localparam logic SRC_DATA  = 1'b1;

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [WORD_BYTES-1:0]      byteen_t;
    typedef logic [CORE_TAG_WIDTH-1:0]  core_tag_t;
    typedef logic [MEM_TAG_WIDTH-1:0]   mem_tag_t;
    typedef logic [SMEM_ADDR_WIDTH-1:0] smem_addr_t;

endpackage
